// ==== tb.f ====
+incdir+hw
hw/vid_pkg.sv
hw/bus_decode.sv
hw/vga_timing.sv
hw/sprite_unit.sv
hw/pixel_combine.sv
hw/display_top.sv
dv/tb_clock.sv
dv/display_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module display_tb \
		-f tb.f -o display_tb
	./obj_dir/display_tb | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/display_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_macros.svh"

module display_tb;

	import vid_pkg::*;

	localparam int LINE_CLOCKS  = 800;
	localparam int FRAME_LINES  = 525;
	localparam int FRAME_CLOCKS = LINE_CLOCKS * FRAME_LINES;
	localparam int SEL_BLANK    = 0;
	localparam int SEL_HSYNC    = 1;
	localparam int SEL_VSYNC    = 2;

	logic        clk;
	logic        reset;
	logic [15:0] addr;
	reg_word_t   write_data;
	logic        write;
	logic        read;
	logic [15:0] read_data;
	logic        blank;
	logic        hsync;
	logic        vsync;
	channel_t    pixel_r;
	channel_t    pixel_g;
	channel_t    pixel_b;

	int          errors;
	int          timeouts;
	reg_word_t   model_pos [`NUM_SPRITES];
	reg_word_t   model_col [`NUM_SPRITES];
	color_word_t model_bg;

	tb_clock u_clock (.clk(clk));

	display_top DUT (
		.clk        (clk),
		.reset      (reset),
		.addr       (addr),
		.write_data (write_data),
		.write      (write),
		.read       (read),
		.read_data  (read_data),
		.blank      (blank),
		.hsync      (hsync),
		.vsync      (vsync),
		.pixel_r    (pixel_r),
		.pixel_g    (pixel_g),
		.pixel_b    (pixel_b)
	);

	//////////////////////////////////////////////////
	// Compare tasks
	task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_pixel(input string name, input int line, input int col,
			input channel_t gr, input channel_t gg, input channel_t gb,
			input channel_t er, input channel_t eg, input channel_t eb);
		if (gr !== er || gg !== eg || gb !== eb) begin
			errors++;
			$display("CHECK FAILED %s line %0d col %0d: got %h_%h_%h expected %h_%h_%h",
				name, line, col, gr, gg, gb, er, eg, eb);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// Bus access 1 ns after the clock edge
	function automatic logic [15:0] page_addr(input int idx);
		return {`GFX_PAGE, 8'h00, 4'(idx)};
	endfunction

	task automatic bus_write(input logic [15:0] a, input reg_word_t w);
		@(posedge clk);
		#1;
		addr = a;
		write_data = w;
		write = 1'b1;
		@(posedge clk);
		#1;
		write = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] a, output reg_word_t data);
		@(posedge clk);
		#1;
		addr = a;
		read = 1'b1;
		@(posedge clk);
		#1;
		read = 1'b0;
		@(negedge clk);
		data = read_data;
	endtask

	// Keeps the reference copy of the registers in step
	task automatic write_reg(input int idx, input reg_word_t w);
		bus_write(page_addr(idx), w);
		if (idx == 0)
			model_bg = w.color;
		else if (idx % 2 == 1)
			model_pos[(idx - 1) / 2] = w;
		else
			model_col[(idx - 2) / 2] = w;
	endtask

	//////////////////////////////////////////////////
	// Edge waits on the video outputs
	function automatic logic level_of(input int which);
		case (which)
			SEL_BLANK: return blank;
			SEL_HSYNC: return hsync;
			default:   return vsync;
		endcase
	endfunction

	task automatic wait_edge(input int which, input logic level, input int limit,
			output int cycles);
		logic prev;
		logic cur;
		bit   found;
		found = 1'b0;
		cycles = 0;
		prev = level_of(which);
		while (!found && cycles < limit) begin
			@(negedge clk);
			cycles++;
			cur = level_of(which);
			found = (prev != level) && (cur == level);
			prev = cur;
		end
		if (!found) begin
			timeouts++;
			$display("Timeout: no %s edge on %s within %0d clocks",
				level ? "rising" : "falling",
				(which == SEL_BLANK) ? "blank" : ((which == SEL_HSYNC) ? "hsync" : "vsync"),
				limit);
		end
	endtask

	//////////////////////////////////////////////////
	// Expected picture
	function automatic color_word_t expected_color(input int col, input int line);
		color_word_t result;
		bit          found;
		int          left;
		int          top;
		result = model_bg;
		found = 1'b0;
		for (int k = 0; k < `NUM_SPRITES; k++) begin
			left = int'(model_pos[k].pos.x_cell) * 8;
			top = int'(model_pos[k].pos.y);
			if (!found && model_col[k].color.enable && col >= left
					&& col < left + `SPRITE_SIZE && line >= top
					&& line < top + `SPRITE_SIZE) begin
				result = model_col[k].color;
				found = 1'b1;
			end
		end
		return result;
	endfunction

	task automatic expected_channels(input color_word_t c, output channel_t r,
			output channel_t g, output channel_t b);
		r = (channel_t'(c.red) << 3) | (channel_t'(c.red) >> 2);
		g = (channel_t'(c.green) << 3) | (channel_t'(c.green) >> 2);
		b = (channel_t'(c.blue) << 3) | (channel_t'(c.blue) >> 2);
	endtask

	// Entered on the clock where blank first went low at column 0
	task automatic scan_line(input int line);
		channel_t r;
		channel_t g;
		channel_t b;
		for (int col = 0; col < `H_VISIBLE; col++) begin
			if (col != 0)
				@(negedge clk);
			expected_channels(expected_color(col, line), r, g, b);
			check_pixel("pixel", line, col, pixel_r, pixel_g, pixel_b, r, g, b);
		end
		for (int i = 0; i < `H_FRONT; i++) begin
			@(negedge clk);
			check_count("blank", int'(blank), 1);
			check_pixel("blanked pixel", line, `H_VISIBLE + i, pixel_r, pixel_g, pixel_b,
				8'h00, 8'h00, 8'h00);
		end
	endtask

	// Lines counted from vsync with one blank fall per visible line
	task automatic scan_lines(input int first, input int last);
		int n;
		wait_edge(SEL_VSYNC, 1'b0, FRAME_CLOCKS + LINE_CLOCKS, n);
		for (int line = 0; line <= last && timeouts == 0; line++) begin
			wait_edge(SEL_BLANK, 1'b0, 40 * LINE_CLOCKS, n);
			if (line >= first && timeouts == 0)
				scan_line(line);
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	task automatic test_readback();
		reg_word_t words [9];
		reg_word_t got;
		for (int i = 0; i < 9; i++) begin
			words[i] = 16'($urandom());
			write_reg(i, words[i]);
		end
		// Same indices on a foreign page
		for (int i = 0; i < 9; i++)
			bus_write({4'($urandom_range(0, 11)), 8'h00, 4'(i)}, ~words[i]);
		for (int i = 0; i < 16; i++) begin
			bus_read(page_addr(i), got);
			check_word($sformatf("read_data index %0d", i), got, (i < 9) ? words[i] : '0);
		end
		for (int k = 0; k < `NUM_SPRITES; k++)
			write_reg(2 + 2 * k, '0);
	endtask

	task automatic test_timing();
		int n;
		int low;
		int rest;
		int pulses;
		int low_lines;
		bit seen_high;
		bit done;
		wait_edge(SEL_HSYNC, 1'b0, 2 * LINE_CLOCKS, n);
		wait_edge(SEL_HSYNC, 1'b1, LINE_CLOCKS, low);
		wait_edge(SEL_HSYNC, 1'b0, LINE_CLOCKS, rest);
		check_count("hsync low clocks", low, `H_SYNC);
		check_count("hsync period clocks", low + rest, LINE_CLOCKS);
		wait_edge(SEL_BLANK, 1'b0, 50 * LINE_CLOCKS, n);
		wait_edge(SEL_BLANK, 1'b1, LINE_CLOCKS, n);
		check_count("blank low clocks", n, `H_VISIBLE);
		wait_edge(SEL_VSYNC, 1'b0, FRAME_CLOCKS + LINE_CLOCKS, n);
		pulses = 0;
		low_lines = 0;
		seen_high = 1'b0;
		done = 1'b0;
		while (!done && timeouts == 0 && pulses < 2 * FRAME_LINES) begin
			wait_edge(SEL_HSYNC, 1'b0, 2 * LINE_CLOCKS, n);
			if (vsync)
				seen_high = 1'b1;
			else if (seen_high)
				done = 1'b1;
			else
				low_lines++;
			// The pulse on the next vsync line belongs to the next frame
			if (!done)
				pulses++;
		end
		check_count("hsync pulses per frame", pulses, FRAME_LINES);
		check_count("vsync low lines", low_lines, `V_SYNC);
	endtask

	task automatic test_background();
		int line;
		write_reg(0, 16'($urandom()));
		line = $urandom_range(0, 477);
		scan_lines(line, line + 1);
	endtask

	task automatic place_sprite(input int k, input int cx, input int y);
		reg_word_t w;
		w.pos.y = 9'(y);
		w.pos.x_cell = 7'(cx);
		write_reg(1 + 2 * k, w);
		w = 16'($urandom());
		w.color.enable = 1'b1;
		write_reg(2 + 2 * k, w);
	endtask

	task automatic disable_sprite(input int k);
		reg_word_t w;
		w = model_col[k];
		w.color.enable = 1'b0;
		write_reg(2 + 2 * k, w);
	endtask

	task automatic test_sprite();
		int k;
		int y;
		k = $urandom_range(0, `NUM_SPRITES - 1);
		y = $urandom_range(1, 470);
		place_sprite(k, $urandom_range(1, 78), y);
		scan_lines(y - 1, y + `SPRITE_SIZE);
		disable_sprite(k);
	endtask

	task automatic test_priority();
		int cx;
		int y;
		cx = $urandom_range(1, 78);
		y = $urandom_range(1, 466);
		place_sprite(1, cx, y);
		place_sprite(2, cx, y + 3);
		scan_lines(y - 1, y + 11);
		disable_sprite(1);
		scan_lines(y - 1, y + 11);
		disable_sprite(2);
		scan_lines(y - 1, y + 11);
	endtask

	initial begin
		void'($urandom(45));
		reset = 1'b1;
		addr = '0;
		write_data = '0;
		write = 1'b0;
		read = 1'b0;
		errors = 0;
		timeouts = 0;
		model_bg = '0;
		for (int k = 0; k < `NUM_SPRITES; k++) begin
			model_pos[k] = '0;
			model_col[k] = '0;
		end
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		test_readback();
		if (timeouts == 0)
			test_timing();
		if (timeouts == 0)
			test_background();
		if (timeouts == 0)
			test_sprite();
		if (timeouts == 0)
			test_priority();

		$display("Mismatches: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	// 8 ns period
	always #4 clk = ~clk;

endmodule

`default_nettype wire

// ==== hw/display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_macros.svh"

module display_top (
	input  logic               clk,
	input  logic               reset,
	input  logic [15:0]        addr,
	input  vid_pkg::reg_word_t write_data,
	input  logic               write,
	input  logic               read,
	output logic [15:0]        read_data,
	output logic               blank,
	output logic               hsync,
	output logic               vsync,
	output vid_pkg::channel_t  pixel_r,
	output vid_pkg::channel_t  pixel_g,
	output vid_pkg::channel_t  pixel_b
);

	import vid_pkg::*;

	logic [`NUM_SPRITES-1:0][1:0]      sprite_we;
	reg_word_t                         reg_wdata;
	color_word_t                       bg_color;
	reg_word_t [`NUM_SPRITES-1:0]      sprite_pos;
	reg_word_t [`NUM_SPRITES-1:0]      sprite_color;
	logic [`NUM_SPRITES-1:0]           sprite_hit;
	color_word_t [`NUM_SPRITES-1:0]    sprite_rgb;
	logic [9:0]                        h_count;
	logic [9:0]                        v_count;
	logic                              visible;
	logic                              hsync_n;
	logic                              vsync_n;

	bus_decode u_decode (
		.clk          (clk),
		.reset        (reset),
		.addr         (addr),
		.write_data   (write_data),
		.write        (write),
		.read         (read),
		.sprite_we    (sprite_we),
		.reg_wdata    (reg_wdata),
		.bg_color     (bg_color),
		.read_data    (read_data),
		.sprite_pos   (sprite_pos),
		.sprite_color (sprite_color)
	);

	vga_timing u_timing (
		.clk     (clk),
		.reset   (reset),
		.h_count (h_count),
		.v_count (v_count),
		.visible (visible),
		.hsync_n (hsync_n),
		.vsync_n (vsync_n)
	);

	//////////////////////////////////////////////////
	// Sprite units
	for (genvar k = 0; k < `NUM_SPRITES; k++) begin : g_sprite
		sprite_unit u_sprite (
			.clk         (clk),
			.reset       (reset),
			.pos_we      (sprite_we[k][0]),
			.color_we    (sprite_we[k][1]),
			.wdata       (reg_wdata),
			.h_count     (h_count),
			.v_count     (v_count),
			.pos_value   (sprite_pos[k]),
			.color_value (sprite_color[k]),
			.hit         (sprite_hit[k]),
			.color       (sprite_rgb[k])
		);
	end

	pixel_combine u_combine (
		.clk          (clk),
		.reset        (reset),
		.hit          (sprite_hit),
		.sprite_color (sprite_rgb),
		.bg_color     (bg_color),
		.visible      (visible),
		.hsync_n      (hsync_n),
		.vsync_n      (vsync_n),
		.pixel_r      (pixel_r),
		.pixel_g      (pixel_g),
		.pixel_b      (pixel_b),
		.blank        (blank),
		.hsync        (hsync),
		.vsync        (vsync)
	);

endmodule

`default_nettype wire

// ==== hw/pixel_combine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_macros.svh"

module pixel_combine (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic [`NUM_SPRITES-1:0]                   hit,
	input  vid_pkg::color_word_t [`NUM_SPRITES-1:0]   sprite_color,
	input  vid_pkg::color_word_t                      bg_color,
	input  logic                                      visible,
	input  logic                                      hsync_n,
	input  logic                                      vsync_n,
	output vid_pkg::channel_t                         pixel_r,
	output vid_pkg::channel_t                         pixel_g,
	output vid_pkg::channel_t                         pixel_b,
	output logic                                      blank,
	output logic                                      hsync,
	output logic                                      vsync
);

	import vid_pkg::*;

	color_word_t pick;
	logic        vis_d1;
	logic        hs_d1;
	logic        vs_d1;

	// 5 to 8 bits by repeating the top bits
	function automatic channel_t expand(input logic [4:0] field);
		return {field, field[4:2]};
	endfunction

	// Lowest index overrides, background underneath
	always_comb begin
		pick = bg_color;
		for (int k = `NUM_SPRITES - 1; k >= 0; k--) begin
			if (hit[k])
				pick = sprite_color[k];
		end
	end

	always_ff @(posedge clk) begin
		pixel_r <= vis_d1 ? expand(pick.red) : '0;
		pixel_g <= vis_d1 ? expand(pick.green) : '0;
		pixel_b <= vis_d1 ? expand(pick.blue) : '0;
	end

	//////////////////////////////////////////////////
	// Two stage delay on sync and visible
	always_ff @(posedge clk) begin
		if (reset) begin
			vis_d1 <= 1'b0;
			hs_d1  <= 1'b1;
			vs_d1  <= 1'b1;
			blank  <= 1'b1;
			hsync  <= 1'b1;
			vsync  <= 1'b1;
		end else begin
			vis_d1 <= visible;
			hs_d1  <= hsync_n;
			vs_d1  <= vsync_n;
			blank  <= !vis_d1;
			hsync  <= hs_d1;
			vsync  <= vs_d1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/sprite_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_macros.svh"

module sprite_unit (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 pos_we,
	input  logic                 color_we,
	input  vid_pkg::reg_word_t   wdata,
	input  logic [9:0]           h_count,
	input  logic [9:0]           v_count,
	output vid_pkg::reg_word_t   pos_value,
	output vid_pkg::reg_word_t   color_value,
	output logic                 hit,
	output vid_pkg::color_word_t color
);

	import vid_pkg::*;

	pos_word_t   pos;
	color_word_t col;
	logic [9:0]  left;
	logic [9:0]  top;
	logic [9:0]  dx;
	logic [9:0]  dy;
	logic        in_x;
	logic        in_y;

	// Sprite registers
	always_ff @(posedge clk) begin
		if (reset) begin
			pos_value   <= '0;
			color_value <= '0;
		end else begin
			if (pos_we)
				pos_value <= wdata;
			if (color_we)
				color_value <= wdata;
		end
	end

	assign pos = pos_value.pos;
	assign col = color_value.color;

	//////////////////////////////////////////////////
	// Coverage of the 8x8 square
	assign left = {pos.x_cell, 3'b000};
	assign top  = {1'b0, pos.y};
	// Offsets wrap when the counter is left of or above the square
	assign dx   = h_count - left;
	assign dy   = v_count - top;
	assign in_x = (h_count >= left) && (dx < 10'(`SPRITE_SIZE));
	assign in_y = (v_count >= top) && (dy < 10'(`SPRITE_SIZE));

	always_ff @(posedge clk) begin
		if (reset)
			hit <= 1'b0;
		else
			hit <= col.enable && in_x && in_y;
	end

	always_ff @(posedge clk) begin
		color <= col;
	end

endmodule

`default_nettype wire

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_macros.svh"

module vga_timing (
	input  logic       clk,
	input  logic       reset,
	output logic [9:0] h_count,
	output logic [9:0] v_count,
	output logic       visible,
	output logic       hsync_n,
	output logic       vsync_n
);

	localparam logic [9:0] H_LAST       = 10'(`H_TOTAL - 1);
	localparam logic [9:0] V_LAST       = 10'(`V_TOTAL - 1);
	localparam logic [9:0] H_SYNC_START = 10'(`H_VISIBLE + `H_FRONT);
	localparam logic [9:0] H_SYNC_END   = 10'(`H_VISIBLE + `H_FRONT + `H_SYNC);
	localparam logic [9:0] V_SYNC_START = 10'(`V_VISIBLE + `V_FRONT);
	localparam logic [9:0] V_SYNC_END   = 10'(`V_VISIBLE + `V_FRONT + `V_SYNC);
	localparam logic [9:0] H_ACTIVE     = 10'(`H_VISIBLE);
	localparam logic [9:0] V_ACTIVE     = 10'(`V_VISIBLE);

	logic [9:0] h_next;
	logic [9:0] v_next;
	logic       vis_next;
	logic       hs_next;
	logic       vs_next;

	//////////////////////////////////////////////////
	// Next counter position
	always_comb begin
		h_next = h_count + 10'd1;
		v_next = v_count;
		if (h_count == H_LAST) begin
			h_next = '0;
			if (v_count == V_LAST)
				v_next = '0;
			else
				v_next = v_count + 10'd1;
		end
	end

	// Levels describe the position they are registered with
	assign vis_next = (h_next < H_ACTIVE) && (v_next < V_ACTIVE);
	assign hs_next  = (h_next >= H_SYNC_START) && (h_next < H_SYNC_END);
	assign vs_next  = (v_next >= V_SYNC_START) && (v_next < V_SYNC_END);

	always_ff @(posedge clk) begin
		if (reset) begin
			h_count <= '0;
			v_count <= '0;
			// Origin is the first active pixel
			visible <= 1'b1;
			hsync_n <= 1'b1;
			vsync_n <= 1'b1;
		end else begin
			h_count <= h_next;
			v_count <= v_next;
			visible <= vis_next;
			hsync_n <= !hs_next;
			vsync_n <= !vs_next;
		end
	end

endmodule

`default_nettype wire

// ==== hw/bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_macros.svh"

module bus_decode (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic [15:0]                             addr,
	input  vid_pkg::reg_word_t                      write_data,
	input  logic                                    write,
	input  logic                                    read,
	output logic [`NUM_SPRITES-1:0][1:0]            sprite_we,
	output vid_pkg::reg_word_t                      reg_wdata,
	output vid_pkg::color_word_t                    bg_color,
	output logic [15:0]                             read_data,
	input  vid_pkg::reg_word_t [`NUM_SPRITES-1:0]   sprite_pos,
	input  vid_pkg::reg_word_t [`NUM_SPRITES-1:0]   sprite_color
);

	import vid_pkg::*;

	logic       on_page;
	logic [3:0] index;
	reg_word_t  read_mux;

	assign on_page   = (addr[15:12] == `GFX_PAGE);
	assign index     = addr[3:0];
	assign reg_wdata = write_data;

	//////////////////////////////////////////////////
	// Write enables, one pair per sprite
	always_comb begin
		for (int k = 0; k < `NUM_SPRITES; k++) begin
			sprite_we[k][0] = write && on_page && (index == 4'(1 + 2 * k));
			sprite_we[k][1] = write && on_page && (index == 4'(2 + 2 * k));
		end
	end

	// Background color register
	always_ff @(posedge clk) begin
		if (reset)
			bg_color <= '0;
		else if (write && on_page && index == `REG_BG)
			bg_color <= write_data.color;
	end

	//////////////////////////////////////////////////
	// Readback select, unmapped indices give zero
	always_comb begin
		read_mux = '0;
		if (index == `REG_BG)
			read_mux.color = bg_color;
		for (int k = 0; k < `NUM_SPRITES; k++) begin
			if (index == 4'(1 + 2 * k))
				read_mux = sprite_pos[k];
			if (index == 4'(2 + 2 * k))
				read_mux = sprite_color[k];
		end
	end

	// Held until the next read on the page
	always_ff @(posedge clk) begin
		if (reset)
			read_data <= '0;
		else if (read && on_page)
			read_data <= read_mux;
	end

endmodule

`default_nettype wire

// ==== hw/vid_pkg.sv ====
`default_nettype none

package vid_pkg;

	// Position view, left edge is x_cell * 8
	typedef struct packed {
		logic [8:0] y;
		logic [6:0] x_cell;
	} pos_word_t;

	// RGB555 color view with sprite enable on top
	typedef struct packed {
		logic       enable;
		logic [4:0] red;
		logic [4:0] green;
		logic [4:0] blue;
	} color_word_t;

	// One bus word, decoded by whichever register it lands in
	typedef union packed {
		pos_word_t   pos;
		color_word_t color;
	} reg_word_t;

	typedef logic [7:0] channel_t;

endpackage

`default_nettype wire

// ==== hw/vid_macros.svh ====
`ifndef VID_MACROS_SVH
`define VID_MACROS_SVH

// Sprite engine size and address map
`define NUM_SPRITES 4
`define GFX_PAGE    4'hC
`define REG_BG      4'd0
`define SPRITE_SIZE 8

// Horizontal timing in pixels, 640x480 at one pixel per clock
`define H_VISIBLE 640
`define H_FRONT   16
`define H_SYNC    96
`define H_BACK    48
`define H_TOTAL   (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical timing in lines
`define V_VISIBLE 480
`define V_FRONT   10
`define V_SYNC    2
`define V_BACK    33
`define V_TOTAL   (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

`endif
